/* FpgaVirtualConsole.f */
ConsolePkg.sv
VgaPkg.sv
UartReceiver.sv
Vt100Parser.sv
TextRam.sv
TextRenderer.sv
FpgaVirtualConsole.sv
tb_FpgaVirtualConsole.sv

/* run.sh */
#!/bin/sh
# build and run the console testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_FpgaVirtualConsole \
    -f FpgaVirtualConsole.f \
    --Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
exit 0

/* tb_FpgaVirtualConsole.sv */
module tb_FpgaVirtualConsole;

    import ConsolePkg::*;
    import VgaPkg::*;

    localparam int Width        = HActive;
    localparam int Height       = VActive;
    localparam int FrameTimeout = 2 * HTotal * VTotal;

    logic clk;
    logic rst;
    logic uartRx;
    logic hsync;
    logic vsync;
    logic de;
    logic pixel;

    int bitClks;
    int errCount;
    int passCount;
    int failCount;

    // screen model with its own escape state
    int   screen [Rows][Cols];
    int   curCol;
    int   curRow;
    int   escState;
    bit   hasParam;
    int   param;
    logic captured [Height][Width];

    FpgaVirtualConsole dut (
        .clk(clk),
        .rst(rst),
        .uartRx(uartRx),
        .hsync(hsync),
        .vsync(vsync),
        .de(de),
        .pixel(pixel)
    );

    always #2 clk = ~clk;

    // glyph rows built from the bits of (code - 32)
    function automatic logic [3:0] fontRow(int code, int line);
        int         index;
        logic [3:0] lo;
        logic [3:0] hi;
        if (code < 32) begin
            return 4'b0000;
        end
        index = code - 32;
        lo = index[3:0];
        hi = index[7:4];
        case (line)
            0:       return lo;
            1:       return hi;
            2:       return {lo[0], lo[1], lo[2], lo[3]};
            default: return {hi[0], hi[1], hi[2], hi[3]};
        endcase
    endfunction

    function automatic void blankScreen();
        for (int r = 0; r < Rows; r++) begin
            for (int c = 0; c < Cols; c++) begin
                screen[r][c] = 32;
            end
        end
    endfunction

    // state of the console right after reset
    function automatic void resetModel();
        blankScreen();
        curCol = 0;
        curRow = 0;
        escState = 0;
        hasParam = 0;
        param = 0;
    endfunction

    function automatic void applyToModel(int b);
        if (escState == 0) begin
            if (b >= 32 && b <= 126) begin
                screen[curRow][curCol] = b;
                if (curCol == Cols - 1) begin
                    curCol = 0;
                    curRow = (curRow + 1) % Rows;
                end else begin
                    curCol++;
                end
            end else if (b == 13) begin
                curCol = 0;
            end else if (b == 10) begin
                curRow = (curRow + 1) % Rows;
            end else if (b == 8 && curCol > 0) begin
                curCol--;
            end else if (b == 27) begin
                escState = 1;
            end
        end else if (escState == 1) begin
            hasParam = 0;
            escState = (b == "[") ? 2 : 0;
        end else if (b >= "0" && b <= "9") begin
            if (!hasParam) begin
                hasParam = 1;
                param = b - "0";
            end
        end else if (b >= 64 && b <= 126) begin
            escState = 0;
            if (b == "J" && hasParam && param == 2) begin
                blankScreen();
            end else if (b == "H" && !hasParam) begin
                curCol = 0;
                curRow = 0;
            end
        end
    endfunction

    // 8N1 frame, optionally with a low stop bit
    task automatic serialSend(logic [7:0] data, bit badStop);
        @(posedge clk);
        uartRx <= 1'b0;
        repeat (bitClks) @(posedge clk);
        for (int i = 0; i < 8; i++) begin
            uartRx <= data[i];
            repeat (bitClks) @(posedge clk);
        end
        uartRx <= !badStop;
        repeat (bitClks) @(posedge clk);
        // idle gap so the byte lands in the text ram
        uartRx <= 1'b1;
        repeat (2 * bitClks) @(posedge clk);
    endtask

    task automatic typeByte(int b);
        serialSend(8'(b), 1'b0);
        applyToModel(b);
    endtask

    task automatic waitVsyncRise(output bit found);
        bit prev;
        int cycles;
        found = 0;
        @(negedge clk);
        prev = vsync;
        for (cycles = 0; cycles < FrameTimeout && !found; cycles++) begin
            @(negedge clk);
            found = vsync && !prev;
            prev = vsync;
        end
    endtask

    // one full frame, from vsync to vsync
    task automatic captureFrame(output bit ok);
        bit found;
        bit prev;
        int cycles;
        int lines;
        int runLen;
        int pixCount;
        ok = 0;
        waitVsyncRise(found);
        if (!found) begin
            $display("timeout: no vsync pulse seen before the frame");
            errCount++;
            return;
        end
        prev = 1'b1;
        found = 0;
        lines = 0;
        runLen = 0;
        pixCount = 0;
        for (cycles = 0; cycles < FrameTimeout && !found; cycles++) begin
            @(negedge clk);
            assert (!(de && hsync)) else begin
                $display("ERROR %0t: hsync high while de is high", $time);
                errCount++;
            end
            assert (de || pixel === 1'b0) else begin
                $display("ERROR %0t: pixel high while de is low", $time);
                errCount++;
            end
            if (de) begin
                if (pixCount < Width * Height) begin
                    captured[pixCount / Width][pixCount % Width] = pixel;
                end
                pixCount++;
                runLen++;
            end else if (runLen != 0) begin
                assert (runLen == Width) else begin
                    $display("ERROR %0t: de line %0d has %0d pixels", $time, lines, runLen);
                    errCount++;
                end
                lines++;
                runLen = 0;
            end
            found = vsync && !prev;
            prev = vsync;
        end
        if (!found) begin
            $display("timeout: frame did not end with a vsync pulse");
            errCount++;
            return;
        end
        assert (lines == Height) else begin
            $display("ERROR %0t: frame has %0d de lines", $time, lines);
            errCount++;
        end
        ok = (lines == Height);
    endtask

    task automatic checkScreen();
        bit         ok;
        logic [3:0] bits;
        logic       expected;
        captureFrame(ok);
        if (!ok) begin
            return;
        end
        for (int y = 0; y < Height; y++) begin
            for (int x = 0; x < Width; x++) begin
                bits = fontRow(screen[y / 4][x / 4], y % 4);
                expected = bits[3 - x % 4];
                assert (captured[y][x] === expected) else begin
                    $display("ERROR %0t: cell (%0d,%0d) pixel (%0d,%0d) got %b expected %b",
                        $time, x / 4, y / 4, x, y, captured[y][x], expected);
                    errCount++;
                end
            end
        end
    endtask

    task automatic endTest(string name, int errBefore);
        if (errCount == errBefore) begin
            $display("%-24s pass", name);
            passCount++;
        end else begin
            $display("%-24s fail, %0d errors", name, errCount - errBefore);
            failCount++;
        end
    endtask

    initial begin
        int errBefore;
        int r;
        clk = 1'b0;
        rst = 1'b1;
        uartRx = 1'b1;
        errCount = 0;
        passCount = 0;
        failCount = 0;
        void'($urandom(92939));
        bitClks = dut.ClksPerBit;
        resetModel();
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // text on screen first, so the clear after a later reset is visible
        errBefore = errCount;
        checkScreen();
        repeat (8) typeByte($urandom_range(126, 33));
        rst <= 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        resetModel();
        checkScreen();
        endTest("reset clear", errBefore);

        errBefore = errCount;
        repeat (40) typeByte($urandom_range(126, 32));
        checkScreen();
        endTest("printable and wrap", errBefore);

        // backspace at column 0 first, then four line feeds to cross the last row
        errBefore = errCount;
        typeByte(13);
        typeByte(8);
        repeat (40) begin
            r = $urandom_range(9);
            if (r < 6) begin
                typeByte($urandom_range(126, 32));
            end else if (r == 6) begin
                typeByte(13);
            end else if (r == 7) begin
                typeByte(10);
            end else begin
                typeByte(8);
            end
        end
        repeat (4) typeByte(10);
        typeByte($urandom_range(126, 32));
        checkScreen();
        endTest("control characters", errBefore);

        errBefore = errCount;
        typeByte(27);
        typeByte("[");
        typeByte("H");
        typeByte("H");
        typeByte("i");
        typeByte("!");
        checkScreen();
        typeByte(27);
        typeByte("[");
        typeByte("2");
        typeByte("J");
        checkScreen();
        typeByte("A");
        checkScreen();
        typeByte(27);
        typeByte("[");
        typeByte("5");
        typeByte("m");
        checkScreen();
        endTest("escape sequences", errBefore);

        // bad frame is not applied to the model
        errBefore = errCount;
        serialSend("Z", 1'b1);
        checkScreen();
        typeByte("q");
        checkScreen();
        endTest("framing error", errBefore);

        $display("tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* FpgaVirtualConsole.sv */
module FpgaVirtualConsole #(
    parameter int ClksPerBit = 8
) (
    input  logic clk,
    input  logic rst,
    input  logic uartRx,
    output logic hsync,
    output logic vsync,
    output logic de,
    output logic pixel
);

    import ConsolePkg::*;

    // uart receiver to parser
    logic       rxValid;
    logic [7:0] rxData;

    // parser write port
    logic       wrEn;
    TextAddr_t  wrAddr;
    Char_t      wrChar;

    // renderer read port
    TextAddr_t  rdAddr;
    Char_t      rdChar;

    UartReceiver #(
        .ClksPerBit(ClksPerBit)
    ) uartReceiver (
        .clk(clk),
        .rst(rst),
        .uartRx(uartRx),
        .rxValid(rxValid),
        .rxData(rxData)
    );

    Vt100Parser vt100Parser (
        .clk(clk),
        .rst(rst),
        .rxValid(rxValid),
        .rxData(rxData),
        .wrEn(wrEn),
        .wrAddr(wrAddr),
        .wrChar(wrChar)
    );

    TextRam textRam (
        .clk(clk),
        .wrEn(wrEn),
        .wrAddr(wrAddr),
        .wrChar(wrChar),
        .rdAddr(rdAddr),
        .rdChar(rdChar)
    );

    TextRenderer renderer (
        .clk(clk),
        .rst(rst),
        .rdAddr(rdAddr),
        .rdChar(rdChar),
        .hsync(hsync),
        .vsync(vsync),
        .de(de),
        .pixel(pixel)
    );

endmodule

/* TextRenderer.sv */
module TextRenderer (
    input  logic                  clk,
    input  logic                  rst,
    output ConsolePkg::TextAddr_t rdAddr,
    input  ConsolePkg::Char_t     rdChar,
    output logic                  hsync,
    output logic                  vsync,
    output logic                  de,
    output logic                  pixel
);

    import ConsolePkg::*;
    import VgaPkg::*;

    HCount_t    hCount;
    VCount_t    vCount;
    logic [6:0] cellIndex;
    logic       activeNow;
    logic       hsyncNow;
    logic       vsyncNow;

    // stage 1, in step with the ram read
    logic       deRead;
    logic       hsyncRead;
    logic       vsyncRead;
    logic [1:0] glyphLineRead;
    logic [1:0] pixColRead;
    GlyphRow_t  glyphBits;

    always_ff @(posedge clk) begin
        if (rst) begin
            hCount <= '0;
            vCount <= '0;
        end else if (hCount == HTotal - 1) begin
            hCount <= '0;
            vCount <= (vCount == VTotal - 1) ? '0 : vCount + 1'b1;
        end else begin
            hCount <= hCount + 1'b1;
        end
    end

    assign activeNow = (hCount < HActive) && (vCount < VActive);
    assign hsyncNow  = (hCount >= HSyncStart) && (hCount < HSyncEnd);
    assign vsyncNow  = (vCount >= VSyncStart) && (vCount < VSyncEnd);

    // cell under the beam, wide enough for the blanking area
    assign cellIndex = 7'((vCount / GlyphH) * Cols + hCount / GlyphW);
    assign rdAddr    = TextAddr_t'(cellIndex);

    always_ff @(posedge clk) begin
        if (rst) begin
            deRead    <= 1'b0;
            hsyncRead <= 1'b0;
            vsyncRead <= 1'b0;
        end else begin
            deRead    <= activeNow;
            hsyncRead <= hsyncNow;
            vsyncRead <= vsyncNow;
        end
    end

    always_ff @(posedge clk) begin
        glyphLineRead <= 2'(vCount % GlyphH);
        pixColRead    <= 2'(hCount % GlyphW);
    end

    assign glyphBits = glyphRow(rdChar, glyphLineRead);

    // stage 2, output register
    always_ff @(posedge clk) begin
        if (rst) begin
            de    <= 1'b0;
            hsync <= 1'b0;
            vsync <= 1'b0;
            pixel <= 1'b0;
        end else begin
            de    <= deRead;
            hsync <= hsyncRead;
            vsync <= vsyncRead;
            pixel <= deRead && glyphBits[GlyphW - 1 - pixColRead];
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(de && hsync));

    // visible positions must fetch a real cell
    assert property (@(posedge clk) disable iff (rst)
        activeNow |-> (cellIndex < Cols * Rows));

endmodule

/* TextRam.sv */
module TextRam (
    input  logic                  clk,
    input  logic                  wrEn,
    input  ConsolePkg::TextAddr_t wrAddr,
    input  ConsolePkg::Char_t     wrChar,
    input  ConsolePkg::TextAddr_t rdAddr,
    output ConsolePkg::Char_t     rdChar
);

    import ConsolePkg::*;

    localparam int Depth = Cols * Rows;

    // one character code per cell
    Char_t mem [Depth];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrChar;
        end
    end

    // registered read, same-cycle write gives the old value
    always_ff @(posedge clk) begin
        rdChar <= mem[rdAddr];
    end

endmodule

/* Vt100Parser.sv */
module Vt100Parser (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rxValid,
    input  logic [7:0]            rxData,
    output logic                  wrEn,
    output ConsolePkg::TextAddr_t wrAddr,
    output ConsolePkg::Char_t     wrChar
);

    import ConsolePkg::*;

    typedef enum logic [1:0] {
        Ground,
        Escape,
        Csi,
        Clear
    } State_t;

    State_t     state;
    Col_t       curCol;
    Row_t       curRow;
    Row_t       nextRow;
    TextAddr_t  cursorAddr;
    TextAddr_t  clearAddr;
    logic       hasParam;
    logic [3:0] param;
    logic       printable;

    assign printable  = (rxData >= 8'd32) && (rxData <= 8'd126);
    assign nextRow    = (curRow == Row_t'(Rows - 1)) ? '0 : curRow + 1'b1;
    assign cursorAddr = TextAddr_t'(curRow * Cols + curCol);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= Clear;
            curCol    <= '0;
            curRow    <= '0;
            clearAddr <= '0;
            hasParam  <= 1'b0;
            wrEn      <= 1'b0;
        end else begin
            wrEn <= 1'b0;
            case (state)
                Clear: begin
                    wrEn      <= 1'b1;
                    clearAddr <= clearAddr + 1'b1;
                    if (clearAddr == TextAddr_t'(Cols * Rows - 1)) begin
                        state <= Ground;
                    end
                end
                Ground: begin
                    if (rxValid && printable) begin
                        wrEn <= 1'b1;
                        if (curCol == Col_t'(Cols - 1)) begin
                            curCol <= '0;
                            curRow <= nextRow;
                        end else begin
                            curCol <= curCol + 1'b1;
                        end
                    end else if (rxValid) begin
                        case (rxData)
                            8'd8: begin
                                if (curCol != '0) begin
                                    curCol <= curCol - 1'b1;
                                end
                            end
                            8'd10: curRow <= nextRow;
                            8'd13: curCol <= '0;
                            8'd27: state <= Escape;
                            default: ;
                        endcase
                    end
                end
                Escape: begin
                    if (rxValid) begin
                        hasParam <= 1'b0;
                        state    <= (rxData == "[") ? Csi : Ground;
                    end
                end
                default: begin
                    // only the first digit counts, later ones are dropped
                    if (rxValid && rxData >= "0" && rxData <= "9") begin
                        if (!hasParam) begin
                            hasParam <= 1'b1;
                            param    <= rxData[3:0];
                        end
                    end else if (rxValid && rxData >= 8'd64 && rxData <= 8'd126) begin
                        state <= Ground;
                        if (rxData == "J" && hasParam && param == 4'd2) begin
                            state     <= Clear;
                            clearAddr <= '0;
                        end else if (rxData == "H" && !hasParam) begin
                            curCol <= '0;
                            curRow <= '0;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == Clear) begin
            wrAddr <= clearAddr;
            wrChar <= Char_t'(32);
        end else begin
            wrAddr <= cursorAddr;
            wrChar <= rxData[6:0];
        end
    end

    // a clear is far shorter than one uart frame
    assert property (@(posedge clk) disable iff (rst) (state == Clear) |-> !rxValid);

endmodule

/* UartReceiver.sv */
module UartReceiver #(
    parameter int ClksPerBit = 8
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       uartRx,
    output logic       rxValid,
    output logic [7:0] rxData
);

    localparam int TimerW = $clog2(ClksPerBit);

    typedef enum logic [2:0] {
        Idle,
        Start,
        Data,
        Stop,
        WaitIdle
    } State_t;

    State_t            state;
    logic              rxMeta;
    logic              rxSync;
    logic [TimerW-1:0] bitTimer;
    logic [2:0]        bitIndex;
    logic              bitDone;
    logic              halfDone;
    logic [7:0]        shiftReg;

    assign bitDone  = (bitTimer == TimerW'(ClksPerBit - 1));
    assign halfDone = (bitTimer == TimerW'(ClksPerBit / 2 - 1));
    assign rxData   = shiftReg;

    always_ff @(posedge clk) begin
        if (rst) begin
            rxMeta   <= 1'b1;
            rxSync   <= 1'b1;
            state    <= Idle;
            bitTimer <= '0;
            bitIndex <= '0;
            rxValid  <= 1'b0;
        end else begin
            rxMeta   <= uartRx;
            rxSync   <= rxMeta;
            rxValid  <= 1'b0;
            bitTimer <= bitTimer + 1'b1;
            case (state)
                Idle: begin
                    bitTimer <= '0;
                    if (!rxSync) begin
                        state <= Start;
                    end
                end
                Start: begin
                    // recheck at mid-bit, a short glitch goes back to idle
                    if (halfDone) begin
                        bitTimer <= '0;
                        bitIndex <= '0;
                        state    <= rxSync ? Idle : Data;
                    end
                end
                Data: begin
                    if (bitDone) begin
                        bitTimer <= '0;
                        bitIndex <= bitIndex + 1'b1;
                        if (bitIndex == 3'd7) begin
                            state <= Stop;
                        end
                    end
                end
                Stop: begin
                    if (bitDone) begin
                        rxValid <= rxSync;
                        state   <= rxSync ? Idle : WaitIdle;
                    end
                end
                default: begin
                    // framing error, hold off until the line is idle again
                    bitTimer <= '0;
                    if (rxSync) begin
                        state <= Idle;
                    end
                end
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clk) begin
        if (state == Data && bitDone) begin
            shiftReg <= {rxSync, shiftReg[7:1]};
        end
    end

endmodule

/* VgaPkg.sv */
package VgaPkg;

    typedef logic [5:0] HCount_t;
    typedef logic [4:0] VCount_t;

    // horizontal raster, in pixels
    localparam HCount_t HActive    = 6'd32;
    localparam HCount_t HSyncStart = 6'd34;
    localparam HCount_t HSyncEnd   = 6'd37;
    localparam HCount_t HTotal     = 6'd40;

    // vertical raster, in lines
    localparam VCount_t VActive    = 5'd16;
    localparam VCount_t VSyncStart = 5'd17;
    localparam VCount_t VSyncEnd   = 5'd18;
    localparam VCount_t VTotal     = 5'd20;

    // both sync pulses are active high

endpackage

/* ConsolePkg.sv */
package ConsolePkg;

    // text grid and glyph cell size
    localparam int Cols   = 8;
    localparam int Rows   = 4;
    localparam int GlyphW = 4;
    localparam int GlyphH = 4;

    typedef logic [6:0] Char_t;
    typedef logic [2:0] Col_t;
    typedef logic [1:0] Row_t;
    // row * Cols + col
    typedef logic [4:0] TextAddr_t;
    // bit 3 is the leftmost pixel
    typedef logic [3:0] GlyphRow_t;

    // rule-based font, each glyph is built from the bits of its own index
    function automatic GlyphRow_t glyphRow(Char_t code, logic [1:0] glyphLine);
        logic [6:0] index;
        GlyphRow_t  lo;
        GlyphRow_t  hi;
        GlyphRow_t  bits;
        index = code - 7'd32;
        lo    = index[3:0];
        hi    = {1'b0, index[6:4]};
        case (glyphLine)
            2'd0:    bits = lo;
            2'd1:    bits = hi;
            2'd2:    bits = {lo[0], lo[1], lo[2], lo[3]};
            default: bits = {hi[0], hi[1], hi[2], hi[3]};
        endcase
        // control codes have no glyph
        if (code < 7'd32) begin
            bits = '0;
        end
        return bits;
    endfunction

endpackage
